/* verilog/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 128;
    localparam int LINE_WORDS = 8;
    // burst length field counts beats minus one
    localparam int BURST_LEN  = LINE_WORDS - 1;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    // address bits 31:12
    typedef logic [19:0] tag_t;
    // address bits 11:5
    typedef logic [6:0]  index_t;
    // address bits 4:2
    typedef logic [2:0]  word_sel_t;
    typedef logic [1:0]  way_t;
    // four way_t entries, entry 0 in bits 1:0 is the most recent
    typedef logic [7:0]  lru_order_t;

    typedef struct packed {
        addr_t addr;
    } cpu_req_t;

    typedef struct packed {
        word_t data;
    } cpu_rsp_t;

    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
    } mem_ar_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } mem_r_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_ADDR,
        REFILL_DATA,
        REREAD,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/icache_tag_store.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_tag_store
(
    input  logic               clk,
    input  logic               rst,
    input  icache_pkg::index_t lookup_index,
    input  icache_pkg::tag_t   lookup_tag,
    input  logic               tag_write,
    input  icache_pkg::way_t   fill_way,
    output logic               hit,
    output icache_pkg::way_t   hit_way
);
    import icache_pkg::*;

    index_t              index_q;
    tag_t                tag_q;
    logic [NUM_WAYS-1:0] way_hit;

    always_ff @(posedge clk)
    begin
        index_q <= lookup_index;
        tag_q   <= lookup_tag;
    end

    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : g_way
        tag_t                tags [NUM_SETS];
        logic [NUM_SETS-1:0] valid;
        logic                write_way;

        assign write_way = tag_write && (fill_way == way_t'(w));

        always_ff @(posedge clk)
        begin
            if (write_way)
            begin
                tags[lookup_index] <= lookup_tag;
            end
        end

        always_ff @(posedge clk)
        begin
            if (rst)
            begin
                valid <= '0;
            end
            else if (write_way)
            begin
                valid[lookup_index] <= 1'b1;
            end
        end

        // compare against the index registered last cycle
        assign way_hit[w] = valid[index_q] && (tags[index_q] == tag_q);
    end

    assign hit = |way_hit;

    // at most one way matches after a clean refill
    always_comb
    begin
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (way_hit[w])
            begin
                hit_way = way_t'(w);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/icache_data_store.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_data_store
(
    input  logic                                   clk,
    input  icache_pkg::index_t                     lookup_index,
    input  icache_pkg::word_sel_t                  lookup_word,
    input  logic                                   fill_en,
    input  icache_pkg::way_t                       fill_way,
    input  icache_pkg::word_sel_t                  fill_word,
    input  icache_pkg::word_t                      fill_data,
    output icache_pkg::word_t [icache_pkg::NUM_WAYS-1:0] way_data
);
    import icache_pkg::*;

    // one bank per way, all read in parallel
    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : g_way
        word_t mem [NUM_SETS][LINE_WORDS];

        always_ff @(posedge clk)
        begin
            if (fill_en && (fill_way == way_t'(w)))
            begin
                mem[lookup_index][fill_word] <= fill_data;
            end
        end

        always_ff @(posedge clk)
        begin
            way_data[w] <= mem[lookup_index][lookup_word];
        end
    end

endmodule

`default_nettype wire

/* verilog/icache_lru.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_lru
(
    input  logic               clk,
    input  logic               rst,
    input  icache_pkg::index_t index,
    input  logic               touch,
    input  icache_pkg::way_t   touch_way,
    output icache_pkg::way_t   victim
);
    import icache_pkg::*;

    lru_order_t order_q [NUM_SETS];
    lru_order_t cur_order;
    lru_order_t next_order;
    way_t       touch_pos;

    assign cur_order = order_q[index];

    // least recent way sits in the last entry
    assign victim = cur_order[7:6];

    always_comb
    begin
        touch_pos = way_t'(NUM_WAYS - 1);
        for (int i = 0; i < NUM_WAYS; i++)
        begin
            if (cur_order[i*2 +: 2] == touch_way)
            begin
                touch_pos = way_t'(i);
            end
        end

        // touched way to the front, entries ahead of it move back one
        next_order = cur_order;
        next_order[1:0] = touch_way;
        for (int i = 1; i < NUM_WAYS; i++)
        begin
            if (i <= int'(touch_pos))
            begin
                next_order[i*2 +: 2] = cur_order[(i-1)*2 +: 2];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                order_q[s] <= {2'd3, 2'd2, 2'd1, 2'd0};
            end
        end
        else if (touch)
        begin
            order_q[index] <= next_order;
        end
    end

endmodule

`default_nettype wire

/* verilog/icache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   req_valid,
    input  icache_pkg::cpu_req_t                   req,
    output logic                                   req_ready,
    output logic                                   rsp_valid,
    output icache_pkg::cpu_rsp_t                   rsp,
    input  logic                                   rsp_ready,
    output logic                                   ar_valid,
    output icache_pkg::mem_ar_t                    ar,
    input  logic                                   ar_ready,
    input  logic                                   r_valid,
    input  icache_pkg::mem_r_t                     r,
    output logic                                   r_ready,
    output icache_pkg::index_t                     lookup_index,
    output icache_pkg::word_sel_t                  lookup_word,
    output icache_pkg::tag_t                       lookup_tag,
    output logic                                   tag_write,
    output logic                                   fill_en,
    output icache_pkg::way_t                       fill_way,
    output icache_pkg::word_sel_t                  fill_word,
    output icache_pkg::word_t                      fill_data,
    output logic                                   touch,
    output icache_pkg::way_t                       touch_way,
    input  logic                                   hit,
    input  icache_pkg::way_t                       hit_way,
    input  icache_pkg::word_t [icache_pkg::NUM_WAYS-1:0] way_data,
    input  icache_pkg::way_t                       victim
);
    import icache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    addr_t       addr_q;
    addr_t       lookup_addr;
    way_t        victim_q;
    word_sel_t   beat_q;
    cpu_rsp_t    rsp_q;
    logic        accept;
    logic        beat;

    assign accept = req_valid && req_ready;
    assign beat   = r_valid && r_ready;

    // stores see the incoming address in the accept cycle
    assign lookup_addr  = (state_q == IDLE) ? req.addr : addr_q;
    assign lookup_index = lookup_addr[11:5];
    assign lookup_word  = lookup_addr[4:2];
    assign lookup_tag   = lookup_addr[31:12];

    always_comb
    begin
        state_d = state_q;
        unique case (state_q)
            IDLE:        if (req_valid) state_d = LOOKUP;
            LOOKUP:      state_d = hit ? RESPOND : REFILL_ADDR;
            REFILL_ADDR: if (ar_ready) state_d = REFILL_DATA;
            REFILL_DATA: if (r_valid && r.last) state_d = REREAD;
            REREAD:      state_d = LOOKUP;
            RESPOND:     if (rsp_ready) state_d = IDLE;
            default:     state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= IDLE;
            beat_q  <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (ar_valid && ar_ready)
            begin
                beat_q <= '0;
            end
            else if (beat)
            begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addr_q <= req.addr;
        end
        if (state_q == LOOKUP && !hit)
        begin
            victim_q <= victim;
        end
        if (state_q == LOOKUP && hit)
        begin
            rsp_q.data <= way_data[hit_way];
        end
    end

    assign req_ready = (state_q == IDLE);
    assign rsp_valid = (state_q == RESPOND);
    assign rsp       = rsp_q;

    // refill always fetches the whole line from word 0
    assign ar_valid = (state_q == REFILL_ADDR);
    assign ar.addr  = {addr_q[31:5], 5'b0};
    assign ar.len   = 8'(BURST_LEN);
    assign r_ready  = (state_q == REFILL_DATA);

    assign fill_en   = beat;
    assign fill_way  = victim_q;
    assign fill_word = beat_q;
    assign fill_data = r.data;
    assign tag_write = beat && r.last;

    assign touch     = (state_q == LOOKUP) && hit;
    assign touch_way = hit_way;

endmodule

`default_nettype wire

/* verilog/icache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_top
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  icache_pkg::cpu_req_t req,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output icache_pkg::cpu_rsp_t rsp,
    input  logic                 rsp_ready,
    output logic                 ar_valid,
    output icache_pkg::mem_ar_t  ar,
    input  logic                 ar_ready,
    input  logic                 r_valid,
    input  icache_pkg::mem_r_t   r,
    output logic                 r_ready
);
    import icache_pkg::*;

    index_t                   lookup_index;
    word_sel_t                lookup_word;
    tag_t                     lookup_tag;
    logic                     tag_write;
    logic                     fill_en;
    way_t                     fill_way;
    word_sel_t                fill_word;
    word_t                    fill_data;
    logic                     touch;
    way_t                     touch_way;
    logic                     hit;
    way_t                     hit_way;
    word_t [NUM_WAYS-1:0]     way_data;
    way_t                     victim;

    icache_ctrl u_ctrl
    (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .rsp_ready    (rsp_ready),
        .ar_valid     (ar_valid),
        .ar           (ar),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r            (r),
        .r_ready      (r_ready),
        .lookup_index (lookup_index),
        .lookup_word  (lookup_word),
        .lookup_tag   (lookup_tag),
        .tag_write    (tag_write),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_word    (fill_word),
        .fill_data    (fill_data),
        .touch        (touch),
        .touch_way    (touch_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .way_data     (way_data),
        .victim       (victim)
    );

    icache_tag_store u_tag_store
    (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .tag_write    (tag_write),
        .fill_way     (fill_way),
        .hit          (hit),
        .hit_way      (hit_way)
    );

    icache_data_store u_data_store
    (
        .clk          (clk),
        .lookup_index (lookup_index),
        .lookup_word  (lookup_word),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_word    (fill_word),
        .fill_data    (fill_data),
        .way_data     (way_data)
    );

    icache_lru u_lru
    (
        .clk          (clk),
        .rst          (rst),
        .index        (lookup_index),
        .touch        (touch),
        .touch_way    (touch_way),
        .victim       (victim)
    );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock
#(
    parameter int PERIOD_NS = 40
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always
    begin
        #(PERIOD_NS / 2);
        clk = ~clk;
    end

endmodule

`default_nettype wire

/* test/mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_model
#(
    parameter logic [31:0] MASK = 32'h0
)
(
    input  logic                clk,
    input  logic                rst,
    input  logic                ar_valid,
    input  icache_pkg::mem_ar_t ar,
    output logic                ar_ready,
    output logic                r_valid,
    output icache_pkg::mem_r_t  r,
    input  logic                r_ready
);
    import icache_pkg::*;

    logic    rst_s;
    logic    ar_hs;
    logic    r_hs;
    mem_ar_t ar_s;
    logic    busy;
    addr_t   base;
    int      beat_cnt;
    int      beats_total;

    initial
    begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
    end

    always @(posedge clk)
    begin
        // handshakes as they happened on this edge
        rst_s = rst;
        ar_hs = ar_valid && ar_ready;
        r_hs  = r_valid && r_ready;
        ar_s  = ar;
        #1;
        if (rst_s)
        begin
            ar_ready    = 1'b0;
            r_valid     = 1'b0;
            r           = '0;
            busy        = 1'b0;
            base        = '0;
            beat_cnt    = 0;
            beats_total = LINE_WORDS;
        end
        else
        begin
            if (ar_hs)
            begin
                busy        = 1'b1;
                base        = ar_s.addr;
                beat_cnt    = 0;
                beats_total = int'(ar_s.len) + 1;
            end
            if (r_hs)
            begin
                beat_cnt++;
                if (beat_cnt == beats_total)
                begin
                    busy = 1'b0;
                end
            end
            // random delay before taking the next address
            ar_ready = !busy && ($urandom_range(1) == 0);
            if (!busy)
            begin
                r_valid = 1'b0;
            end
            else if (!r_valid || r_hs)
            begin
                r_valid = ($urandom_range(3) != 0);
            end
            r.data = (base + 32'(beat_cnt) * 4) ^ MASK;
            r.last = (beat_cnt == beats_total - 1);
        end
    end

endmodule

`default_nettype wire

/* test/icache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          NUM_TESTS    = 300;
    localparam int          NUM_REUSE    = 40;
    localparam logic [31:0] SEED         = 32'h1394;
    localparam word_t       MEM_MASK     = 32'h5A3C_96E1;
    localparam int          TIMEOUT_NS   = NUM_TESTS * 40 * CLK_PERIOD;
    localparam index_t      CONFLICT_SET = 7'd9;

    logic     clk;
    logic     rst;
    logic     req_valid;
    cpu_req_t req;
    logic     req_ready;
    logic     rsp_valid;
    cpu_rsp_t rsp;
    logic     rsp_ready;
    logic     ar_valid;
    mem_ar_t  ar;
    logic     ar_ready;
    logic     r_valid;
    mem_r_t   r;
    logic     r_ready;

    tag_t   tag_pool [6] = '{20'h00010, 20'h00023, 20'h1F004, 20'h0ABCD, 20'h7FFFF, 20'hC0DE1};
    index_t set_pool [4] = '{7'd9, 7'd0, 7'd77, 7'd127};

    // reference copy of tags, valid bits and recency order
    tag_t  model_tag   [NUM_SETS][NUM_WAYS];
    logic  model_valid [NUM_SETS][NUM_WAYS];
    way_t  model_order [NUM_SETS][NUM_WAYS];

    addr_t cur_addr;
    int    ar_count;
    int    hits;
    int    misses;
    int    evictions;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk(clk));

    icache_top uut
    (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready)
    );

    mem_model #(.MASK(MEM_MASK)) u_mem
    (
        .clk      (clk),
        .rst      (rst),
        .ar_valid (ar_valid),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r        (r),
        .r_ready  (r_ready)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic addr_t make_addr(input tag_t tag, input index_t idx, input word_sel_t word);
        return {tag, idx, word, 2'b00};
    endfunction

    function automatic void clear_model();
        for (int s = 0; s < NUM_SETS; s++)
        begin
            for (int w = 0; w < NUM_WAYS; w++)
            begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
                model_order[s][w] = way_t'(w);
            end
        end
    endfunction

    function automatic int find_way(input addr_t addr);
        index_t idx;
        idx = addr[11:5];
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (model_valid[idx][w] && model_tag[idx][w] == addr[31:12])
            begin
                return w;
            end
        end
        return -1;
    endfunction

    // move a way to the front of its set's order
    function automatic void promote_way(input index_t idx, input way_t way);
        int pos;
        pos = NUM_WAYS - 1;
        for (int i = 0; i < NUM_WAYS; i++)
        begin
            if (model_order[idx][i] == way)
            begin
                pos = i;
            end
        end
        for (int i = pos; i > 0; i--)
        begin
            model_order[idx][i] = model_order[idx][i-1];
        end
        model_order[idx][0] = way;
    endfunction

    task automatic issue_request(input addr_t addr);
        index_t idx;
        int     exp_way;
        way_t   victim;
        int     ar_before;
        int     n;
        int     first_valid;
        word_t  held;
        logic   done;

        idx       = addr[11:5];
        exp_way   = find_way(addr);
        ar_before = ar_count;
        cur_addr  = addr;
        req_valid = 1'b1;
        req.addr  = addr;
        @(negedge clk);
        while (!req_ready)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid   = 1'b0;
        req.addr    = $urandom();
        n           = 0;
        first_valid = 0;
        held        = '0;
        done        = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            n++;
            check_value("req_ready", req_ready, 0);
            if (first_valid != 0)
            begin
                check_value("rsp_valid held", rsp_valid, 1);
            end
            if (rsp_valid)
            begin
                if (first_valid == 0)
                begin
                    first_valid = n;
                    held        = rsp.data;
                end
                check_value("rsp.data held", rsp.data, held);
                done = rsp_ready;
            end
        end
        check_value("rsp.data", rsp.data, addr ^ MEM_MASK);
        if (exp_way >= 0)
        begin
            hits++;
            check_value("hit latency", first_valid, 2);
            check_value("ar count on hit", ar_count - ar_before, 0);
            promote_way(idx, way_t'(exp_way));
        end
        else
        begin
            misses++;
            check_value("ar count on miss", ar_count - ar_before, 1);
            victim = model_order[idx][NUM_WAYS-1];
            if (model_valid[idx][victim])
            begin
                evictions++;
            end
            model_tag[idx][victim]   = addr[31:12];
            model_valid[idx][victim] = 1'b1;
            promote_way(idx, victim);
        end
        @(posedge clk);
        #1;
    endtask

    // ar handshake happens at the next rising edge
    always @(negedge clk)
    begin
        if (!rst && ar_valid && ar_ready)
        begin
            ar_count++;
            check_value("ar.addr", ar.addr, {cur_addr[31:5], 5'b00000});
            check_value("ar.len", ar.len, BURST_LEN);
        end
    end

    always @(posedge clk)
    begin
        #1;
        rsp_ready = ($urandom_range(2) != 0);
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        void'($urandom(SEED));
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        cur_addr  = '0;
        ar_count  = 0;
        hits      = 0;
        misses    = 0;
        evictions = 0;
        clear_model();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("req_ready after reset", req_ready, 1);
        check_value("rsp_valid after reset", rsp_valid, 0);
        check_value("ar_valid after reset", ar_valid, 0);
        check_value("r_ready after reset", r_ready, 0);
        @(posedge clk);
        #1;

        // five tags into one set, then reuse in random order
        for (int t = 0; t < 5; t++)
        begin
            issue_request(make_addr(tag_pool[t], CONFLICT_SET, word_sel_t'($urandom_range(7))));
        end
        for (int n = 0; n < NUM_REUSE; n++)
        begin
            issue_request(make_addr(tag_pool[$urandom_range(4)], CONFLICT_SET,
                                    word_sel_t'($urandom_range(7))));
        end

        for (int n = 5 + NUM_REUSE; n < NUM_TESTS; n++)
        begin
            repeat ($urandom_range(2))
            begin
                @(posedge clk);
                #1;
            end
            issue_request(make_addr(tag_pool[$urandom_range(5)], set_pool[$urandom_range(3)],
                                    word_sel_t'($urandom_range(7))));
        end

        $display("requests %0d, hits %0d, misses %0d, evictions %0d",
                 NUM_TESTS, hits, misses, evictions);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
verilog/icache_pkg.sv
verilog/icache_tag_store.sv
verilog/icache_data_store.sv
verilog/icache_lru.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
test/tb_clock.sv
test/mem_model.sv
test/icache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile with Verilator, run, then search the log for the fail message

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module icache_tb -f sim.f -o icache_sim \
    && ./obj_dir/icache_sim 2>&1 | tee sim.log \
    || echo "build or run error" | tee -a sim.log

grep -q "SIMULATION PASSED" sim.log && ! grep -q "SIMULATION FAILED" sim.log \
    && { echo "result: pass"; exit 0; } \
    || { echo "result: fail"; exit 1; }
